// ==== exec_pkg.sv ====
package exec_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths

    localparam int xlen        = 32;         // operand and result width
    localparam int pr_bits     = 6;          // physical register tag
    localparam int rob_bits    = 5;          // reorder buffer index
    localparam int mult_stages = 4;          // multiplier pipeline depth
    localparam int op_bits     = 4;          // opcode field width
    localparam int shamt_bits  = 5;          // shift amount taken from opb
    localparam int prod_bits   = 2 * xlen;   // full unsigned product

    ////////////////////////////////////////////////////////////////////////////
    // opcodes

    // alu class first, multiply class at the top of the encoding
    typedef enum logic [op_bits-1:0] {
        op_add   = 4'd0,
        op_sub   = 4'd1,
        op_and   = 4'd2,
        op_or    = 4'd3,
        op_xor   = 4'd4,
        op_sll   = 4'd5,   // shift left by opb[4:0]
        op_srl   = 4'd6,   // logical shift right by opb[4:0]
        op_slt   = 4'd7,   // signed compare, result 1 or 0
        op_mul   = 4'd8,   // low half of unsigned product
        op_mulhu = 4'd9    // high half of unsigned product
    } exec_op_e;

    ////////////////////////////////////////////////////////////////////////////
    // packets

    // one issued operation, 79 bits
    typedef struct packed {
        exec_op_e            op;
        logic [xlen-1:0]     opa;
        logic [xlen-1:0]     opb;
        logic [pr_bits-1:0]  dest_pr;   // where the result goes
        logic [rob_bits-1:0] rob_idx;   // rob entry to mark complete
    } issue_pkt_t;

    // one completed result on the cdb, 43 bits
    typedef struct packed {
        logic [xlen-1:0]     value;
        logic [pr_bits-1:0]  dest_pr;
        logic [rob_bits-1:0] rob_idx;
    } cdb_pkt_t;

    // payload of one multiplier stage
    typedef struct packed {
        logic [prod_bits-1:0] product;  // full 64 bit product
        logic                 sel_hi;   // mulhu takes the upper half
        logic [pr_bits-1:0]   dest_pr;
        logic [rob_bits-1:0]  rob_idx;
    } mult_stage_t;

endpackage

// ==== alu_unit.sv ====
`timescale 1ns/100ps

module alu_unit import exec_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  logic       issue_valid,
    input  issue_pkt_t issue_pkt,
    input  logic       alu_take,     // arbiter takes the held result
    output logic       alu_ready,
    output logic       alu_done,
    output cdb_pkt_t   alu_result
);

    logic            is_alu_op;   // opcode belongs to this unit
    logic            accept;      // issue transfer into the alu
    logic [xlen-1:0] alu_value;   // combinational result

    ////////////////////////////////////////////////////////////////////////////
    // decode and handshake

    // everything except the two multiply opcodes
    assign is_alu_op = (issue_pkt.op != op_mul) && (issue_pkt.op != op_mulhu);

    // room when the output reg is empty or drains this cycle
    assign alu_ready = is_alu_op && (!alu_done || alu_take);
    assign accept    = issue_valid && alu_ready;

    ////////////////////////////////////////////////////////////////////////////
    // datapath

    always_comb begin
        case (issue_pkt.op)
            op_add:  alu_value = issue_pkt.opa + issue_pkt.opb;
            op_sub:  alu_value = issue_pkt.opa - issue_pkt.opb;
            op_and:  alu_value = issue_pkt.opa & issue_pkt.opb;
            op_or:   alu_value = issue_pkt.opa | issue_pkt.opb;
            op_xor:  alu_value = issue_pkt.opa ^ issue_pkt.opb;
            op_sll:  alu_value = issue_pkt.opa << issue_pkt.opb[shamt_bits-1:0];
            op_srl:  alu_value = issue_pkt.opa >> issue_pkt.opb[shamt_bits-1:0];
            op_slt: begin
                // signed compare, zero extended flag
                alu_value = ($signed(issue_pkt.opa) < $signed(issue_pkt.opb)) ?
                            {{(xlen-1){1'b0}}, 1'b1} : '0;
            end
            default: alu_value = '0;   // multiply opcodes never accepted here
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // output register

    always_ff @(posedge clock) begin
        if (reset) begin
            alu_done <= 1'b0;
        end else if (accept) begin
            alu_done <= 1'b1;              // new result replaces or refills
        end else if (alu_take) begin
            alu_done <= 1'b0;              // drained, nothing behind it
        end
    end

    // payload only moves on acceptance, held while waiting for the cdb
    always_ff @(posedge clock) begin
        if (accept) begin
            alu_result.value   <= alu_value;
            alu_result.dest_pr <= issue_pkt.dest_pr;
            alu_result.rob_idx <= issue_pkt.rob_idx;
        end
    end

endmodule

// ==== mult_unit.sv ====
`timescale 1ns/100ps

module mult_unit import exec_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  logic       issue_valid,
    input  issue_pkt_t issue_pkt,
    input  logic       mult_take,    // arbiter takes the last stage
    output logic       mult_ready,
    output logic       mult_done,
    output cdb_pkt_t   mult_result
);

    logic                   is_mult_op;    // mul or mulhu offered
    logic                   advance;       // whole chain moves this cycle
    logic                   accept;        // issue transfer into stage 0
    logic [prod_bits-1:0]   product_in;    // product of the offered operands
    mult_stage_t            stage_in;      // stage 0 load value

    logic [mult_stages-1:0] stage_valid;   // one valid bit per stage
    mult_stage_t            stage_data [mult_stages];

    ////////////////////////////////////////////////////////////////////////////
    // decode and chain control

    assign is_mult_op = (issue_pkt.op == op_mul) || (issue_pkt.op == op_mulhu);

    // last stage empty or leaving -> every stage can shift by one
    assign advance    = !stage_valid[mult_stages-1] || mult_take;

    // ready only when stage 0 can move, i.e. the chain advances
    assign mult_ready = is_mult_op && advance;
    assign accept     = issue_valid && mult_ready;

    ////////////////////////////////////////////////////////////////////////////
    // first stage product

    // unsigned multiply, both halves kept until the end of the chain
    assign product_in = prod_bits'(issue_pkt.opa) * prod_bits'(issue_pkt.opb);

    always_comb begin
        stage_in.product = product_in;
        stage_in.sel_hi  = (issue_pkt.op == op_mulhu);
        stage_in.dest_pr = issue_pkt.dest_pr;
        stage_in.rob_idx = issue_pkt.rob_idx;
    end

    ////////////////////////////////////////////////////////////////////////////
    // pipeline registers

    // valid bits, bubbles shift along with the data
    always_ff @(posedge clock) begin
        if (reset) begin
            stage_valid <= '0;
        end else if (advance) begin
            stage_valid <= {stage_valid[mult_stages-2:0], accept};
        end
    end

    // payload, frozen together with the valid bits
    always_ff @(posedge clock) begin
        if (advance) begin
            stage_data[0] <= stage_in;
            for (int i = 1; i < mult_stages; i++) begin
                stage_data[i] <= stage_data[i-1];
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // result select

    assign mult_done = stage_valid[mult_stages-1];

    always_comb begin
        // mulhu wants bits 63:32, mul wants 31:0
        if (stage_data[mult_stages-1].sel_hi) begin
            mult_result.value = stage_data[mult_stages-1].product[prod_bits-1:xlen];
        end else begin
            mult_result.value = stage_data[mult_stages-1].product[xlen-1:0];
        end
        mult_result.dest_pr = stage_data[mult_stages-1].dest_pr;
        mult_result.rob_idx = stage_data[mult_stages-1].rob_idx;
    end

endmodule

// ==== complete_arbiter.sv ====
`timescale 1ns/100ps

module complete_arbiter import exec_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  logic     alu_done,
    input  cdb_pkt_t alu_result,
    input  logic     mult_done,
    input  cdb_pkt_t mult_result,
    input  logic     cdb_ready,     // consumer accepts the broadcast
    output logic     alu_take,
    output logic     mult_take,
    output logic     cdb_valid,
    output cdb_pkt_t cdb_pkt
);

    logic     can_load;   // cdb register empty or emptied this cycle
    logic     load;       // one of the units is granted
    cdb_pkt_t grant_pkt;  // result of the granted unit

    ////////////////////////////////////////////////////////////////////////////
    // grant

    // cdb register full and not accepted -> back-pressure to both units
    assign can_load = !cdb_valid || cdb_ready;

    // multiplier first, it holds the older op
    assign mult_take = can_load && mult_done;
    assign alu_take  = can_load && alu_done && !mult_done;
    assign load      = mult_take || alu_take;

    always_comb begin
        if (mult_take) begin
            grant_pkt = mult_result;
        end else begin
            grant_pkt = alu_result;   // only loaded when alu_take
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // cdb register

    always_ff @(posedge clock) begin
        if (reset) begin
            cdb_valid <= 1'b0;
        end else if (load) begin
            cdb_valid <= 1'b1;
        end else if (cdb_ready) begin
            cdb_valid <= 1'b0;        // broadcast done, nothing new
        end
    end

    // holds steady while the consumer stalls
    always_ff @(posedge clock) begin
        if (load) begin
            cdb_pkt <= grant_pkt;
        end
    end

endmodule

// ==== exec_cluster.sv ====
`timescale 1ns/100ps

module exec_cluster import exec_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  logic       issue_valid,
    input  issue_pkt_t issue_pkt,
    output logic       issue_ready,
    output logic       cdb_valid,
    output cdb_pkt_t   cdb_pkt,
    input  logic       cdb_ready
);

    logic     alu_ready;     // alu can take the offered op
    logic     mult_ready;    // multiplier can take the offered op
    logic     alu_done;
    logic     mult_done;
    logic     alu_take;
    logic     mult_take;
    cdb_pkt_t alu_result;
    cdb_pkt_t mult_result;

    // each unit only raises ready for its own opcode class
    assign issue_ready = alu_ready | mult_ready;

    ////////////////////////////////////////////////////////////////////////////
    // functional units

    alu_unit alu_0 (
        .clock       (clock),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue_pkt   (issue_pkt),
        .alu_take    (alu_take),      // <- arbiter
        .alu_ready   (alu_ready),
        .alu_done    (alu_done),      // -> arbiter
        .alu_result  (alu_result)     // -> arbiter
    );

    mult_unit mult_0 (
        .clock       (clock),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue_pkt   (issue_pkt),
        .mult_take   (mult_take),     // <- arbiter
        .mult_ready  (mult_ready),
        .mult_done   (mult_done),     // -> arbiter
        .mult_result (mult_result)    // -> arbiter
    );

    ////////////////////////////////////////////////////////////////////////////
    // complete stage

    complete_arbiter complete_0 (
        .clock       (clock),
        .reset       (reset),
        .alu_done    (alu_done),
        .alu_result  (alu_result),
        .mult_done   (mult_done),
        .mult_result (mult_result),
        .cdb_ready   (cdb_ready),
        .alu_take    (alu_take),
        .mult_take   (mult_take),
        .cdb_valid   (cdb_valid),     // -> cdb broadcast
        .cdb_pkt     (cdb_pkt)
    );

endmodule

// ==== exec_cluster_chk.sv ====
`timescale 1ns/100ps

module exec_cluster_chk import exec_pkg::*; (
    input logic     clock,
    input logic     reset,
    input logic     cdb_valid,
    input logic     cdb_ready,
    input cdb_pkt_t cdb_pkt,
    input logic     alu_done,
    input logic     alu_take,
    input logic     mult_done,
    input logic     mult_take
);

    ////////////////////////////////////////////////////////////////////////////
    // cdb handshake

    // stalled broadcast stays put
    cdb_hold: assert property (@(posedge clock) disable iff (reset)
        cdb_valid && !cdb_ready |=> cdb_valid && $stable(cdb_pkt))
        else $error("cdb packet changed or dropped while stalled");

    cdb_reset: assert property (@(posedge clock) reset |=> !cdb_valid)
        else $error("cdb_valid high in the cycle after reset");

    ////////////////////////////////////////////////////////////////////////////
    // arbiter grants

    one_take: assert property (@(posedge clock) disable iff (reset)
        !(alu_take && mult_take))
        else $error("alu and multiplier granted together");

    alu_take_done: assert property (@(posedge clock) disable iff (reset)
        alu_take |-> alu_done)
        else $error("alu result taken without alu_done");

    mult_take_done: assert property (@(posedge clock) disable iff (reset)
        mult_take |-> mult_done)
        else $error("multiplier result taken without mult_done");

endmodule

bind exec_cluster exec_cluster_chk chk_0 (
    .clock     (clock),
    .reset     (reset),
    .cdb_valid (cdb_valid),
    .cdb_ready (cdb_ready),
    .cdb_pkt   (cdb_pkt),
    .alu_done  (alu_done),
    .alu_take  (alu_take),
    .mult_done (mult_done),
    .mult_take (mult_take)
);

// ==== exec_monitor.sv ====
`timescale 1ns/100ps

module exec_monitor import exec_pkg::*; (
    input  logic            clock,
    input  logic            reset,
    input  logic            issue_valid,
    input  logic            issue_ready,
    input  issue_pkt_t      issue_pkt,
    input  logic [xlen-1:0] exp_value,     // expected result of the offered op
    input  logic            cdb_valid,
    input  logic            cdb_ready,
    input  cdb_pkt_t        cdb_pkt,
    output int              error_count,
    output int              result_count,
    output int              pending_count
);

    localparam int rob_size = 1 << rob_bits;

    logic [xlen-1:0]     exp_val_by_rob [rob_size];
    logic [pr_bits-1:0]  exp_tag_by_rob [rob_size];
    logic [rob_size-1:0] busy;          // rob entries waiting for the cdb
    logic                reset_q;
    logic                stalled_q;     // cdb was valid and not accepted
    cdb_pkt_t            stalled_pkt;

    task report_mismatch(input string name, input logic [63:0] exp, input logic [63:0] act);
        $display("mismatch at %0t: %s expected %0h got %0h", $time, name, exp, act);
        error_count++;
    endtask

    task report_failure(input string what);
        $display("error at %0t: %s", $time, what);
        error_count++;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // scoreboard

    always @(posedge clock) begin : sample
        logic [rob_bits-1:0] idx;
        if (reset) begin
            busy          = '0;
            stalled_q     = 1'b0;
            error_count   = 0;
            result_count  = 0;
            pending_count = 0;
        end else begin
            if (reset_q) begin                       // first cycle out of reset
                if (cdb_valid !== 1'b0) report_failure("cdb_valid high right after reset");
                if (issue_ready !== 1'b1) report_failure("issue_ready low right after reset");
            end
            if ($isunknown(cdb_valid)) report_failure("cdb_valid is unknown");

            // a stalled broadcast must come back unchanged
            if (stalled_q) begin
                if (cdb_valid !== 1'b1) begin
                    report_failure("cdb_valid dropped before the broadcast was accepted");
                end else if (cdb_pkt !== stalled_pkt) begin
                    report_mismatch("cdb_pkt", 64'(stalled_pkt), 64'(cdb_pkt));
                end
            end

            if (cdb_valid && cdb_ready) begin
                idx = cdb_pkt.rob_idx;
                if ($isunknown(cdb_pkt)) begin
                    report_failure("cdb packet has unknown bits");
                end else if (!busy[idx]) begin
                    report_failure($sformatf("broadcast for rob index %0d not outstanding", idx));
                end else begin
                    if (cdb_pkt.value !== exp_val_by_rob[idx])
                        report_mismatch("cdb_pkt.value", 64'(exp_val_by_rob[idx]),
                                        64'(cdb_pkt.value));
                    if (cdb_pkt.dest_pr !== exp_tag_by_rob[idx])
                        report_mismatch("cdb_pkt.dest_pr", 64'(exp_tag_by_rob[idx]),
                                        64'(cdb_pkt.dest_pr));
                    busy[idx] = 1'b0;
                    pending_count--;
                    result_count++;
                end
            end

            if (issue_valid && issue_ready) begin
                idx = issue_pkt.rob_idx;
                if (busy[idx]) report_failure($sformatf("rob index %0d issued twice", idx));
                exp_val_by_rob[idx] = exp_value;
                exp_tag_by_rob[idx] = issue_pkt.dest_pr;
                busy[idx]           = 1'b1;
                pending_count++;
            end

            stalled_q   = cdb_valid && !cdb_ready;
            stalled_pkt = cdb_pkt;
        end
        reset_q = reset;
    end

endmodule

// ==== tb_exec_cluster.sv ====
`timescale 1ns/100ps

module tb_exec_cluster import exec_pkg::*; ();

    localparam int num_rows     = 40;
    localparam int reset_cycles = 3;
    localparam int cycle_limit  = reset_cycles + num_rows * (mult_stages + 1) * 4;

    // one stimulus row with its hand-worked expected value
    typedef struct packed {
        exec_op_e        op;
        logic [xlen-1:0] opa;
        logic [xlen-1:0] opb;
        logic [xlen-1:0] exp_val;
        logic [3:0]      gap;       // idle cycles before the row
    } stim_row_t;

    logic            clock     = 1'b0;
    logic            cdb_ready = 1'b0;
    logic            reset;
    logic            issue_valid;
    issue_pkt_t      issue_pkt;
    logic            issue_ready;
    logic            cdb_valid;
    cdb_pkt_t        cdb_pkt;
    logic [xlen-1:0] exp_value;     // travels with issue_pkt to the monitor

    int error_count;
    int result_count;
    int pending_count;
    int run_errors;
    int seed_value;
    int cycle_count = 0;

    stim_row_t stim_table [num_rows];

    ////////////////////////////////////////////////////////////////////////////
    // dut and monitor

    exec_cluster UUT (
        .clock       (clock),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue_pkt   (issue_pkt),
        .issue_ready (issue_ready),
        .cdb_valid   (cdb_valid),
        .cdb_pkt     (cdb_pkt),
        .cdb_ready   (cdb_ready)
    );

    exec_monitor mon_0 (
        .clock         (clock),
        .reset         (reset),
        .issue_valid   (issue_valid),
        .issue_ready   (issue_ready),
        .issue_pkt     (issue_pkt),
        .exp_value     (exp_value),
        .cdb_valid     (cdb_valid),
        .cdb_ready     (cdb_ready),
        .cdb_pkt       (cdb_pkt),
        .error_count   (error_count),
        .result_count  (result_count),
        .pending_count (pending_count)
    );

    always #4 clock = ~clock;   // 8 ns period

    // consumer stalls on about a third of the cycles
    always @(posedge clock) begin
        if (reset) begin
            cdb_ready <= 1'b1;
        end else begin
            cdb_ready <= ($urandom % 3) != 0;
        end
    end

    // run limit
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles, operations still outstanding", cycle_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus

    task fill_stimulus_table;
        stim_table[ 0] = '{op_add,   32'h0000_0005, 32'h0000_0007, 32'h0000_000c, 4'd0};
        stim_table[ 1] = '{op_sub,   32'h0000_000a, 32'h0000_0003, 32'h0000_0007, 4'd0};
        stim_table[ 2] = '{op_sub,   32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 4'd1};
        stim_table[ 3] = '{op_and,   32'hf0f0_f0f0, 32'hff00_ff00, 32'hf000_f000, 4'd0};
        stim_table[ 4] = '{op_or,    32'hf0f0_f0f0, 32'h0f0f_0f0f, 32'hffff_ffff, 4'd0};
        stim_table[ 5] = '{op_xor,   32'haaaa_5555, 32'hffff_0000, 32'h5555_5555, 4'd2};
        stim_table[ 6] = '{op_sll,   32'h0000_0001, 32'h0000_001f, 32'h8000_0000, 4'd0};
        stim_table[ 7] = '{op_sll,   32'h1234_5678, 32'h0000_0024, 32'h2345_6780, 4'd0};
        stim_table[ 8] = '{op_srl,   32'h8000_0000, 32'h0000_001f, 32'h0000_0001, 4'd0};
        stim_table[ 9] = '{op_srl,   32'hf000_0000, 32'h0000_0024, 32'h0f00_0000, 4'd1};
        stim_table[10] = '{op_slt,   32'hffff_ffff, 32'h0000_0001, 32'h0000_0001, 4'd0};
        stim_table[11] = '{op_slt,   32'h0000_0005, 32'hffff_fffe, 32'h0000_0000, 4'd0};
        stim_table[12] = '{op_mul,   32'h0000_0003, 32'h0000_0004, 32'h0000_000c, 4'd2};
        stim_table[13] = '{op_mulhu, 32'h0000_0003, 32'h0000_0004, 32'h0000_0000, 4'd0};
        stim_table[14] = '{op_mul,   32'hffff_ffff, 32'hffff_ffff, 32'h0000_0001, 4'd0};
        stim_table[15] = '{op_mulhu, 32'hffff_ffff, 32'hffff_ffff, 32'hffff_fffe, 4'd0};
        stim_table[16] = '{op_mul,   32'h0001_0000, 32'h0001_0000, 32'h0000_0000, 4'd0};
        stim_table[17] = '{op_mulhu, 32'h0001_0000, 32'h0001_0000, 32'h0000_0001, 4'd0};
        stim_table[18] = '{op_add,   32'hffff_ffff, 32'h0000_0001, 32'h0000_0000, 4'd0};
        stim_table[19] = '{op_mul,   32'h1234_5678, 32'h0000_0010, 32'h2345_6780, 4'd3};
        stim_table[20] = '{op_mulhu, 32'h1234_5678, 32'h0000_0010, 32'h0000_0001, 4'd0};
        stim_table[21] = '{op_xor,   32'h1234_5678, 32'h1234_5678, 32'h0000_0000, 4'd0};
        stim_table[22] = '{op_add,   32'h7fff_ffff, 32'h0000_0001, 32'h8000_0000, 4'd0};
        stim_table[23] = '{op_mul,   32'h0000_03e8, 32'h0000_03e8, 32'h000f_4240, 4'd0};
        stim_table[24] = '{op_slt,   32'h8000_0000, 32'h7fff_ffff, 32'h0000_0001, 4'd1};
        stim_table[25] = '{op_mulhu, 32'h8000_0000, 32'h0000_0004, 32'h0000_0002, 4'd0};
        stim_table[26] = '{op_sub,   32'h0000_0100, 32'h0000_0001, 32'h0000_00ff, 4'd0};
        stim_table[27] = '{op_srl,   32'hffff_ffff, 32'h0000_0004, 32'h0fff_ffff, 4'd0};
        stim_table[28] = '{op_mul,   32'hffff_ffff, 32'h0000_0002, 32'hffff_fffe, 4'd0};
        stim_table[29] = '{op_mulhu, 32'hffff_ffff, 32'h0000_0002, 32'h0000_0001, 4'd0};
        stim_table[30] = '{op_or,    32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 4'd2};
        stim_table[31] = '{op_and,   32'hffff_ffff, 32'h0000_beef, 32'h0000_beef, 4'd0};
        stim_table[32] = '{op_mul,   32'h0000_0007, 32'h0000_0006, 32'h0000_002a, 4'd0};
        stim_table[33] = '{op_sll,   32'hffff_ffff, 32'h0000_0000, 32'hffff_ffff, 4'd0};
        stim_table[34] = '{op_slt,   32'h0000_0003, 32'h0000_0003, 32'h0000_0000, 4'd0};
        stim_table[35] = '{op_mulhu, 32'hffff_0000, 32'hffff_0000, 32'hfffe_0001, 4'd0};
        stim_table[36] = '{op_add,   32'h1111_1111, 32'h2222_2222, 32'h3333_3333, 4'd0};
        stim_table[37] = '{op_mul,   32'h0000_0000, 32'hdead_beef, 32'h0000_0000, 4'd1};
        stim_table[38] = '{op_sub,   32'h0000_0005, 32'h0000_0007, 32'hffff_fffe, 4'd0};
        stim_table[39] = '{op_xor,   32'hffff_ffff, 32'h0f0f_0f0f, 32'hf0f0_f0f0, 4'd0};
    endtask

    // offer one row and hold it until the cluster takes it
    task automatic apply_row(input int row);
        stim_row_t r;
        r = stim_table[row];
        repeat (r.gap) begin
            issue_valid <= 1'b0;
            @(posedge clock);
        end
        issue_valid       <= 1'b1;
        issue_pkt.op      <= r.op;
        issue_pkt.opa     <= r.opa;
        issue_pkt.opb     <= r.opb;
        issue_pkt.dest_pr <= pr_bits'(row + 16);
        issue_pkt.rob_idx <= rob_bits'(row);    // wraps past 31 once the old entry is long gone
        exp_value         <= r.exp_val;
        @(posedge clock);
        while (!issue_ready) begin
            @(posedge clock);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence

    initial begin
        seed_value  = $urandom(76400);
        run_errors  = 0;
        reset       = 1'b1;
        issue_valid = 1'b0;
        issue_pkt   = '0;
        exp_value   = '0;
        fill_stimulus_table();

        repeat (reset_cycles) @(posedge clock);
        reset <= 1'b0;
        @(posedge clock);

        for (int row = 0; row < num_rows; row++) begin
            apply_row(row);
        end
        issue_valid <= 1'b0;

        // drain and allow a few spare cycles for stray broadcasts
        @(negedge clock);
        while (pending_count != 0) begin
            @(negedge clock);
        end
        repeat (4) @(negedge clock);

        // every rob entry completed so nothing may be left on the cdb
        if (cdb_valid !== 1'b0) begin
            $display("error: cdb still holds a broadcast after all operations completed");
            run_errors++;
        end
        $display("results %0d of %0d, monitor errors %0d, run errors %0d",
                 result_count, num_rows, error_count, run_errors);
        if (error_count == 0 && run_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== project.f ====
exec_pkg.sv
alu_unit.sv
mult_unit.sv
complete_arbiter.sv
exec_cluster.sv
exec_cluster_chk.sv
exec_monitor.sv
tb_exec_cluster.sv

// ==== run.sh ====
#!/bin/bash
# build and run the exec_cluster testbench with verilator
rm -rf obj_dir sim.log build.log
verilator --binary --assert --timing -j 0 --top-module tb_exec_cluster \
    -f project.f -o sim_exec_cluster > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_exec_cluster > sim.log 2>&1 \
    || echo "simulation stopped with an error" >> sim.log
cat sim.log
! grep -q "TEST FAILED" sim.log && grep -q "TEST OK" sim.log \
    && echo "PASS" || { echo "FAIL"; exit 1; }
